/* rtl/rv_pipe_pkg.sv */
`default_nettype none

package rv_pipe_pkg;

	localparam int XLEN  = 64;
	localparam int NREGS = 32;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [31:0]     inst_t;

	// ******************************
	// opcodes and function codes.
	// ******************************
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_BEQ     = 3'b000;

	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR
	} alu_op_t;

	// ******************************
	// stage payloads.
	// ******************************
	typedef struct packed {
		inst_t inst;
		xlen_t pc;
	} if_id_t;

	typedef struct packed {
		xlen_t    op_a;
		xlen_t    op_b;
		xlen_t    imm;
		xlen_t    pc;
		reg_idx_t rd;
		logic     reg_write;
		logic     alu_src;
		logic     branch;
		alu_op_t  alu_op;
	} id_ex_t;

	typedef struct packed {
		xlen_t    result;
		reg_idx_t rd;
		logic     result_we;
		logic     branch_taken;
		xlen_t    branch_target;
	} ex_out_t;

endpackage

`default_nettype wire

/* rtl/stage_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic [7:0]
) (
	input  wire      clk,
	input  wire      arst_n,
	input  wire      en,
	input  wire      payload_t d,
	output payload_t q
);

	// holds its contents while en is low.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0; // a zero record is a bubble.
		end else if (en) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  wire                             clk,
	input  wire                             arst_n,
	input  wire rv_pipe_pkg::reg_idx_t      rs1,
	input  wire rv_pipe_pkg::reg_idx_t      rs2,
	output rv_pipe_pkg::xlen_t              rd1,
	output rv_pipe_pkg::xlen_t              rd2,
	input  wire                             we,
	input  wire rv_pipe_pkg::reg_idx_t      wd_idx,
	input  wire rv_pipe_pkg::xlen_t         wd
);

	import rv_pipe_pkg::*;

	xlen_t regs [NREGS];

	// x0 reads zero, a same cycle write is forwarded.
	function automatic xlen_t read_port(input reg_idx_t idx);
		if (idx == '0) begin
			return '0;
		end
		if (we && (wd_idx == idx)) begin
			return wd;
		end
		return regs[idx];
	endfunction

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wd_idx != '0)) begin
			regs[wd_idx] <= wd; // writes to x0 are dropped.
		end
	end

	always_comb begin
		rd1 = read_port(rs1);
		rd2 = read_port(rs2);
	end

endmodule

`default_nettype wire

/* rtl/ctrl_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrl_decode (
	input  wire rv_pipe_pkg::inst_t  inst,
	output logic                     reg_write,
	output logic                     alu_src,
	output logic                     branch,
	output rv_pipe_pkg::alu_op_t     alu_op,
	output rv_pipe_pkg::xlen_t       imm,
	output rv_pipe_pkg::reg_idx_t    rd
);

	import rv_pipe_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       alt_op; // funct7 bit 5.
	xlen_t      imm_i;
	xlen_t      imm_b;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign alt_op = inst[30];

	assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
	assign imm_b = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

	always_comb begin
		// bubble unless a supported instruction matches.
		reg_write = 1'b0;
		alu_src   = 1'b0;
		branch    = 1'b0;
		alu_op    = ALU_ADD;
		imm       = '0;

		case (opcode)
			OPC_OP: begin
				case (funct3)
					F3_ADD_SUB: begin
						reg_write = 1'b1;
						alu_op    = alt_op ? ALU_SUB : ALU_ADD;
					end
					F3_AND: begin
						reg_write = 1'b1;
						alu_op    = ALU_AND;
					end
					F3_OR: begin
						reg_write = 1'b1;
						alu_op    = ALU_OR;
					end
					default: ;
				endcase
			end
			OPC_OP_IMM: begin
				if (funct3 == F3_ADD_SUB) begin // addi only.
					reg_write = 1'b1;
					alu_src   = 1'b1;
					imm       = imm_i;
				end
			end
			OPC_BRANCH: begin
				if (funct3 == F3_BEQ) begin
					branch = 1'b1;
					alu_op = ALU_SUB; // equal operands give a zero result.
					imm    = imm_b;
				end
			end
			default: ;
		endcase
	end

	assign rd = reg_write ? inst[11:7] : '0;

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
	input  wire rv_pipe_pkg::xlen_t     op_a,
	input  wire rv_pipe_pkg::xlen_t     op_b,
	input  wire rv_pipe_pkg::xlen_t     imm,
	input  wire rv_pipe_pkg::xlen_t     pc,
	input  wire                         alu_src,
	input  wire                         branch,
	input  wire                         reg_write,
	input  wire rv_pipe_pkg::alu_op_t   alu_op,
	input  wire rv_pipe_pkg::reg_idx_t  rd,
	output rv_pipe_pkg::xlen_t          result,
	output logic                        result_we,
	output rv_pipe_pkg::reg_idx_t       result_rd,
	output logic                        branch_taken,
	output rv_pipe_pkg::xlen_t          branch_target
);

	import rv_pipe_pkg::*;

	xlen_t operand_b;
	logic  zero;

	assign operand_b = alu_src ? imm : op_b;

	// ******************************
	// alu.
	// ******************************
	always_comb begin
		case (alu_op)
			ALU_SUB: result = op_a - operand_b;
			ALU_AND: result = op_a & operand_b;
			ALU_OR:  result = op_a | operand_b;
			default: result = op_a + operand_b;
		endcase
	end

	assign zero = (result == '0);

	// ******************************
	// branch and write enable.
	// ******************************
	assign branch_taken  = branch & zero;
	assign branch_target = pc + imm; // pc relative, imm already shifted.

	assign result_we = reg_write; // rd 0 is filtered in the register file.
	assign result_rd = rd;

endmodule

`default_nettype wire

/* rtl/decode_exec_top.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_exec_top (
	input  wire                         clk,
	input  wire                         arst_n,
	input  wire                         en,
	input  wire rv_pipe_pkg::inst_t     inst,
	input  wire rv_pipe_pkg::xlen_t     pc,
	input  wire                         wb_en,
	input  wire rv_pipe_pkg::reg_idx_t  wb_rd,
	input  wire rv_pipe_pkg::xlen_t     wb_data,
	output rv_pipe_pkg::xlen_t          result,
	output rv_pipe_pkg::reg_idx_t       result_rd,
	output logic                        result_we,
	output logic                        branch_taken,
	output rv_pipe_pkg::xlen_t          branch_target
);

	import rv_pipe_pkg::*;

	if_id_t   if_id_d, if_id_q;
	id_ex_t   id_ex_d, id_ex_q;
	ex_out_t  ex_out_d, ex_out_q;

	reg_idx_t rs1, rs2;
	xlen_t    rd1, rd2;
	logic     dec_reg_write, dec_alu_src, dec_branch;
	alu_op_t  dec_alu_op;
	xlen_t    dec_imm;
	reg_idx_t dec_rd;

	xlen_t    ex_result, ex_target;
	reg_idx_t ex_rd;
	logic     ex_we, ex_taken;

	// ******************************
	// if/id.
	// ******************************
	assign if_id_d = '{inst: inst, pc: pc};

	stage_reg #(.payload_t(if_id_t)) u_if_id (
		.clk    (clk),
		.arst_n (arst_n),
		.en     (en),
		.d      (if_id_d),
		.q      (if_id_q)
	);

	assign rs1 = if_id_q.inst[19:15];
	assign rs2 = if_id_q.inst[24:20];

	reg_file u_reg_file (
		.clk    (clk),
		.arst_n (arst_n),
		.rs1    (rs1),
		.rs2    (rs2),
		.rd1    (rd1),
		.rd2    (rd2),
		.we     (wb_en),
		.wd_idx (wb_rd),
		.wd     (wb_data)
	);

	ctrl_decode u_ctrl_decode (
		.inst      (if_id_q.inst),
		.reg_write (dec_reg_write),
		.alu_src   (dec_alu_src),
		.branch    (dec_branch),
		.alu_op    (dec_alu_op),
		.imm       (dec_imm),
		.rd        (dec_rd)
	);

	// ******************************
	// id/ex.
	// ******************************
	assign id_ex_d = '{op_a: rd1, op_b: rd2, imm: dec_imm, pc: if_id_q.pc, rd: dec_rd,
		reg_write: dec_reg_write, alu_src: dec_alu_src, branch: dec_branch,
		alu_op: dec_alu_op};

	stage_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk    (clk),
		.arst_n (arst_n),
		.en     (en),
		.d      (id_ex_d),
		.q      (id_ex_q)
	);

	exec_unit u_exec_unit (
		.op_a          (id_ex_q.op_a),
		.op_b          (id_ex_q.op_b),
		.imm           (id_ex_q.imm),
		.pc            (id_ex_q.pc),
		.alu_src       (id_ex_q.alu_src),
		.branch        (id_ex_q.branch),
		.reg_write     (id_ex_q.reg_write),
		.alu_op        (id_ex_q.alu_op),
		.rd            (id_ex_q.rd),
		.result        (ex_result),
		.result_we     (ex_we),
		.result_rd     (ex_rd),
		.branch_taken  (ex_taken),
		.branch_target (ex_target)
	);

	// ******************************
	// ex/out.
	// ******************************
	assign ex_out_d = '{result: ex_result, rd: ex_rd, result_we: ex_we,
		branch_taken: ex_taken, branch_target: ex_target};

	stage_reg #(.payload_t(ex_out_t)) u_ex_out (
		.clk    (clk),
		.arst_n (arst_n),
		.en     (en),
		.d      (ex_out_d),
		.q      (ex_out_q)
	);

	assign result        = ex_out_q.result;
	assign result_rd     = ex_out_q.rd;
	assign result_we     = ex_out_q.result_we;
	assign branch_taken  = ex_out_q.branch_taken;
	assign branch_target = ex_out_q.branch_target;

endmodule

`default_nettype wire

/* testbench/tb_decode_exec_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_decode_exec_top;

	import rv_pipe_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int NROWS        = 12;
	localparam int MAX_CYCLES   = 40 * NROWS + RESET_CYCLES;

	localparam logic [2:0] K_ADD  = 3'd0;
	localparam logic [2:0] K_SUB  = 3'd1;
	localparam logic [2:0] K_AND  = 3'd2;
	localparam logic [2:0] K_OR   = 3'd3;
	localparam logic [2:0] K_ADDI = 3'd4;
	localparam logic [2:0] K_BEQ  = 3'd5;

	typedef struct packed {
		logic [2:0]  kind;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [12:0] imm;    // signed, even for branches.
		logic        bypass; // write rs1 back during decode.
		logic        exp_we;
	} row_t;

	logic     clk, arst_n, en, wb_en, result_we, branch_taken;
	inst_t    inst;
	xlen_t    pc, wb_data, result, branch_target;
	reg_idx_t wb_rd, result_rd;

	row_t  rows [NROWS];
	xlen_t model [32]; // reference copy of the register file.
	int    errors = 0;
	int    tests  = 0;
	int    failed = 0;
	int    cycles = 0;

	decode_exec_top UUT (
		.clk           (clk),
		.arst_n        (arst_n),
		.en            (en),
		.inst          (inst),
		.pc            (pc),
		.wb_en         (wb_en),
		.wb_rd         (wb_rd),
		.wb_data       (wb_data),
		.result        (result),
		.result_rd     (result_rd),
		.result_we     (result_we),
		.branch_taken  (branch_taken),
		.branch_target (branch_target)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run went past %0d cycles", MAX_CYCLES);
			$display("Finished with errors");
			$finish;
		end
	end

	// ******************************
	// reference model.
	// ******************************
	function automatic inst_t encode(input row_t r);
		logic [12:0] b;
		b = r.imm;
		case (r.kind)
			K_ADD:   return {7'b0000000, r.rs2, r.rs1, 3'b000, r.rd, OPC_OP};
			K_SUB:   return {7'b0100000, r.rs2, r.rs1, 3'b000, r.rd, OPC_OP};
			K_AND:   return {7'b0000000, r.rs2, r.rs1, 3'b111, r.rd, OPC_OP};
			K_OR:    return {7'b0000000, r.rs2, r.rs1, 3'b110, r.rd, OPC_OP};
			K_ADDI:  return {b[11:0], r.rs1, 3'b000, r.rd, OPC_OP_IMM};
			default: return {b[12], b[10:5], r.rs2, r.rs1, 3'b000, b[4:1], b[11], OPC_BRANCH};
		endcase
	endfunction

	function automatic xlen_t alu_ref(input row_t r, input xlen_t a, input xlen_t b);
		xlen_t imm;
		imm = {{51{r.imm[12]}}, r.imm};
		case (r.kind)
			K_SUB, K_BEQ: return a - b;
			K_AND:        return a & b;
			K_OR:         return a | b;
			K_ADDI:       return a + imm;
			default:      return a + b;
		endcase
	endfunction

	// ******************************
	// checks.
	// ******************************
	task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic check_outputs(input row_t r, input xlen_t pc_v);
		xlen_t a, b;
		a = model[r.rs1];
		b = model[r.rs2];
		check_word("result", result, alu_ref(r, a, b));
		check_bit("result_we", result_we, r.exp_we);
		check_bit("branch_taken", branch_taken, (r.kind == K_BEQ) && (a == b));
		if (r.exp_we) begin
			check_idx("result_rd", result_rd, r.rd);
		end
		// the target is known wherever an immediate is decoded.
		if ((r.kind == K_BEQ) || (r.kind == K_ADDI)) begin
			check_word("branch_target", branch_target, pc_v + {{51{r.imm[12]}}, r.imm});
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed++;
			$display("test %0d %s: failed", tests, name);
		end
	endtask

	// one instruction alone through the pipe.
	task automatic run_row(input int n);
		row_t  r;
		int    err_before;
		xlen_t pc_v;
		r = rows[n];
		err_before = errors;
		pc_v = 64'h1000 + xlen_t'(4 * n);
		inst = encode(r);
		pc = pc_v;
		@(negedge clk);
		inst = '0;
		if (r.bypass) begin
			wb_en = 1'b1;
			wb_rd = r.rs1;
			wb_data = {$urandom, $urandom};
			if (r.rs1 != '0) model[r.rs1] = wb_data;
		end
		@(negedge clk);
		wb_en = 1'b0;
		check_bit("result_we before latency", result_we, 1'b0);
		@(negedge clk);
		check_outputs(r, pc_v);
		report_test($sformatf("row %0d", n), err_before);
	endtask

	// three back to back, frozen for five cycles, then drained.
	task automatic run_stall_test();
		int idx [3];
		int err_before;
		idx = '{4, 0, 1};
		err_before = errors;
		for (int i = 0; i < 3; i++) begin
			inst = encode(rows[idx[i]]);
			pc = 64'h2000 + xlen_t'(4 * i);
			@(negedge clk);
		end
		inst = '0;
		en = 1'b0;
		check_outputs(rows[idx[0]], 64'h2000);
		repeat (5) begin
			@(negedge clk);
			check_outputs(rows[idx[0]], 64'h2000);
		end
		en = 1'b1;
		for (int i = 1; i < 3; i++) begin
			@(negedge clk);
			check_outputs(rows[idx[i]], 64'h2000 + xlen_t'(4 * i));
		end
		report_test("stall", err_before);
	endtask

	initial begin
		int err_before;
		void'($urandom(47002));
		arst_n = 1'b0;
		en = 1'b1;
		inst = '0;
		pc = '0;
		wb_en = 1'b0;
		wb_rd = '0;
		wb_data = '0;
		for (int i = 0; i < 32; i++) begin
			model[i] = '0;
		end
		//        kind    rd     rs1    rs2    imm         bypass exp_we
		rows = '{
			'{K_ADD,  5'd10, 5'd1,  5'd2,  13'sd0,     1'b0, 1'b1},
			'{K_SUB,  5'd11, 5'd3,  5'd4,  13'sd0,     1'b0, 1'b1},
			'{K_AND,  5'd12, 5'd5,  5'd6,  13'sd0,     1'b0, 1'b1},
			'{K_OR,   5'd13, 5'd7,  5'd8,  13'sd0,     1'b0, 1'b1},
			'{K_ADDI, 5'd14, 5'd9,  5'd0,  13'sd100,   1'b0, 1'b1},
			'{K_ADDI, 5'd15, 5'd10, 5'd0,  -13'sd2048, 1'b0, 1'b1},
			'{K_BEQ,  5'd0,  5'd11, 5'd11, 13'sd64,    1'b0, 1'b0},
			'{K_BEQ,  5'd0,  5'd12, 5'd13, -13'sd16,   1'b0, 1'b0},
			'{K_OR,   5'd16, 5'd0,  5'd0,  13'sd0,     1'b0, 1'b1},
			'{K_ADDI, 5'd17, 5'd0,  5'd0,  -13'sd1,    1'b0, 1'b1},
			'{K_ADD,  5'd18, 5'd20, 5'd21, 13'sd0,     1'b1, 1'b1},
			'{K_SUB,  5'd19, 5'd22, 5'd23, 13'sd0,     1'b1, 1'b1}
		};

		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		err_before = errors;
		check_bit("result_we", result_we, 1'b0);
		check_bit("branch_taken", branch_taken, 1'b0);
		report_test("reset", err_before);

		// random operands in every register, x0 must stay zero.
		for (int i = 0; i < 32; i++) begin
			wb_en = 1'b1;
			wb_rd = reg_idx_t'(i);
			wb_data = {$urandom, $urandom};
			if (i != 0) model[i] = wb_data;
			@(negedge clk);
		end
		wb_en = 1'b0;

		for (int n = 0; n < NROWS; n++) begin
			run_row(n);
		end
		run_stall_test();

		$display("%0d tests, %0d failed, %0d check errors", tests, failed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* decode_exec_top.f */
rtl/rv_pipe_pkg.sv
rtl/stage_reg.sv
rtl/reg_file.sv
rtl/ctrl_decode.sv
rtl/exec_unit.sv
rtl/decode_exec_top.sv
testbench/tb_decode_exec_top.sv

/* Makefile */
SIM := obj_dir/Vtb_decode_exec_top

.PHONY: all run clean

all: $(SIM)

$(SIM): decode_exec_top.f rtl/*.sv testbench/*.sv
	verilator --binary --timing --top-module tb_decode_exec_top \
		-f decode_exec_top.f -o Vtb_decode_exec_top

# the run fails unless the pass line shows up in the output.
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
